//--- all.f
+incdir+test
rtl/agp32_pkg.sv
rtl/instr_decode.sv
rtl/register_file.sv
rtl/forward_unit.sv
rtl/execute_unit.sv
rtl/mem_controller.sv
rtl/agp32_core.sv
test/tb_agp32.sv

//--- rtl/agp32_core.sv
`timescale 1ns/1ps

module agp32_core
  import agp32_pkg::*;
#(
  parameter word_t reset_pc = 32'd0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ready,
  input  word_t                inst_rdata,
  input  word_t                data_rdata,
  output word_t                pc,
  output word_t                data_addr,
  output word_t                data_wdata,
  output mem_cmd_e             command,
  output logic [3:0]           data_wstrb,
  output logic [out_width-1:0] data_out
);

  localparam word_t nop_word = 32'd63;

  word_t    fetched;
  word_t    id_pc;
  word_t    id_instr;
  decoded_t dec;
  word_t    rd_a;
  word_t    rd_b;
  word_t    rd_w;
  id_ex_t   id_next;
  id_ex_t   ex_q;
  ex_mem_t  ex_res;
  ex_mem_t  mem_q;
  ex_mem_t  mem_view;
  mem_wb_t  wb_q;
  word_t    mem_imm;
  word_t    wb_data;
  word_t    load_data;
  word_t    jump_addr;
  logic     jump_taken;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;
  fwd_sel_e fwd_w;
  logic     pc_en;
  logic     id_en;
  logic     ex_en;
  logic     mem_en;
  logic     wb_en;
  logic     flush_id;
  logic     nop_ex;

  assign fetched = ready ? inst_rdata : nop_word;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (pc_en) begin
      pc <= jump_taken ? jump_addr : pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush_id) begin
      id_instr <= nop_word;
    end else if (id_en) begin
      id_instr <= fetched;
      id_pc    <= pc;
    end
  end

  instr_decode u_decode (
    .instr (id_instr),
    .dec   (dec)
  );

  register_file u_regs (
    .clk     (clk),
    .reset   (reset),
    .addr_a  (dec.addr_a),
    .addr_b  (dec.addr_b),
    .addr_w  (dec.addr_w),
    .wr_addr (wb_q.addr_w),
    .wr_en   (wb_q.wr && wb_en),
    .wr_data (wb_data),
    .rd_a    (rd_a),
    .rd_b    (rd_b),
    .rd_w    (rd_w)
  );

  // Immediate operands are the sign-extended register fields.
  always_comb begin
    id_next.pc  = id_pc;
    id_next.dec = dec;
    id_next.a   = dec.imm_a ? {{26{dec.addr_a[5]}}, dec.addr_a} : rd_a;
    id_next.b   = dec.imm_b ? {{26{dec.addr_b[5]}}, dec.addr_b} : rd_b;
    id_next.w   = dec.imm_w ? {{26{dec.addr_w[5]}}, dec.addr_w} : rd_w;
    if (nop_ex) begin
      id_next.dec.opc = op_nop;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_q.dec.opc <= op_nop;
    end else if (ex_en) begin
      ex_q <= id_next;
    end else if (mem_en) begin
      // The held instruction keeps the values forwarded from the retiring one.
      ex_q.a <= ex_res.a;
      ex_q.b <= ex_res.b;
      ex_q.w <= ex_res.w;
    end
  end

  forward_unit u_fwd (
    .ex_addr_a  (ex_q.dec.addr_a),
    .ex_addr_b  (ex_q.dec.addr_b),
    .ex_addr_w  (ex_q.dec.addr_w),
    .ex_imm_a   (ex_q.dec.imm_a),
    .ex_imm_b   (ex_q.dec.imm_b),
    .ex_imm_w   (ex_q.dec.imm_w),
    .ex_opc     (ex_q.dec.opc),
    .mem_addr_w (mem_q.addr_w),
    .wb_addr_w  (wb_q.addr_w),
    .mem_opc    (mem_q.opc),
    .mem_wr     (mem_q.wr),
    .wb_wr      (wb_q.wr),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .fwd_w      (fwd_w)
  );

  execute_unit u_exec (
    .ex         (ex_q),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .fwd_w      (fwd_w),
    .mem        (mem_view),
    .wb_data    (wb_data),
    .clk        (clk),
    .reset      (reset),
    .ex_en      (ex_en),
    .res        (ex_res),
    .jump_taken (jump_taken),
    .jump_addr  (jump_addr)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_q.opc <= op_nop;
      mem_q.wr  <= 1'b0;
    end else if (mem_en) begin
      if (ex_en) begin
        mem_q <= ex_res;
      end else begin
        mem_q.opc <= op_nop;
        mem_q.wr  <= 1'b0;
      end
    end
  end

  // Upper-constant load keeps the low 23 bits of the old W value.
  always_comb begin
    mem_imm = (mem_q.opc == op_load_upper) ? {mem_q.imm[8:0], mem_q.w[22:0]} : mem_q.imm;
    mem_view     = mem_q;
    mem_view.imm = mem_imm;
  end

  mem_controller u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .ready      (ready),
    .jump_taken (jump_taken),
    .mem_opc    (mem_q.opc),
    .mem_a      (mem_q.a),
    .mem_b      (mem_q.b),
    .pc_en      (pc_en),
    .id_en      (id_en),
    .ex_en      (ex_en),
    .mem_en     (mem_en),
    .wb_en      (wb_en),
    .flush_id   (flush_id),
    .nop_ex     (nop_ex),
    .command    (command),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_wstrb (data_wstrb)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_q.opc <= op_nop;
      wb_q.wr  <= 1'b0;
    end else if (wb_en) begin
      wb_q.pc     <= mem_q.pc;
      wb_q.a      <= mem_q.a;
      wb_q.imm    <= mem_imm;
      wb_q.alu    <= mem_q.alu;
      wb_q.shift  <= mem_q.shift;
      wb_q.addr_w <= mem_q.addr_w;
      wb_q.opc    <= mem_q.opc;
      wb_q.wr     <= mem_q.wr;
    end
  end

  // Read data is captured as the load enters writeback.
  always_ff @(posedge clk) begin
    if (wb_en) begin
      load_data <= data_rdata;
    end
  end

  always_comb begin
    case (wb_q.opc)
      op_shift:                     wb_data = wb_q.shift;
      op_jump:                      wb_data = wb_q.pc + 32'd4;
      op_load_const, op_load_upper: wb_data = wb_q.imm;
      op_load:                      wb_data = load_data;
      default:                      wb_data = wb_q.alu;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else if (wb_en && (wb_q.opc == op_out)) begin
      data_out <= wb_q.alu[out_width-1:0];
    end
  end

endmodule

//--- rtl/agp32_pkg.sv
package agp32_pkg;

  typedef logic [31:0] word_t;
  typedef logic [5:0]  reg_addr_t;
  typedef logic [3:0]  func_t;

  // Width of the output port driven by the out instruction.
  localparam int out_width = 10;

  // Encodings follow the opcode field of the instruction word.
  typedef enum logic [4:0] {
    op_normal       = 5'd0,
    op_shift        = 5'd1,
    op_store        = 5'd2,
    op_load         = 5'd4,
    op_out          = 5'd6,
    op_jump         = 5'd9,
    op_jump_zero    = 5'd10,
    op_jump_nonzero = 5'd11,
    op_load_const   = 5'd13,
    op_load_upper   = 5'd14,
    op_nop          = 5'd15
  } opcode_e;

  // Source of an execute operand.
  typedef enum logic [2:0] {
    fwd_reg   = 3'd0,
    fwd_wb    = 3'd1,
    fwd_alu   = 3'd2,
    fwd_shift = 3'd3,
    fwd_pc4   = 3'd4,
    fwd_imm   = 3'd5
  } fwd_sel_e;

  typedef enum logic [2:0] {
    cmd_none  = 3'd0,
    cmd_read  = 3'd2,
    cmd_write = 3'd3
  } mem_cmd_e;

  typedef enum logic [1:0] {
    st_run,
    st_wait_mem,
    st_resume
  } ctrl_state_e;

  typedef struct packed {
    reg_addr_t addr_a;
    reg_addr_t addr_b;
    reg_addr_t addr_w;
    logic      imm_a;
    logic      imm_b;
    logic      imm_w;
    opcode_e   opc;
    func_t     func;
    word_t     imm;
  } decoded_t;

  typedef struct packed {
    word_t    pc;
    decoded_t dec;
    word_t    a;
    word_t    b;
    word_t    w;
  } id_ex_t;

  typedef struct packed {
    word_t     pc;
    word_t     a;
    word_t     b;
    word_t     w;
    word_t     imm;
    word_t     alu;
    word_t     shift;
    reg_addr_t addr_w;
    opcode_e   opc;
    logic      wr;
  } ex_mem_t;

  typedef struct packed {
    word_t     pc;
    word_t     a;
    word_t     imm;
    word_t     alu;
    word_t     shift;
    reg_addr_t addr_w;
    opcode_e   opc;
    logic      wr;
  } mem_wb_t;

endpackage

//--- rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
  import agp32_pkg::*;
(
  input  id_ex_t   ex,
  input  fwd_sel_e fwd_a,
  input  fwd_sel_e fwd_b,
  input  fwd_sel_e fwd_w,
  input  ex_mem_t  mem,
  input  word_t    wb_data,
  input  logic     clk,
  input  logic     reset,
  input  logic     ex_en,
  output ex_mem_t  res,
  output logic     jump_taken,
  output word_t    jump_addr
);

  word_t       op_a;
  word_t       op_b;
  word_t       op_w;
  word_t       in1;
  word_t       in2;
  word_t       diff;
  word_t       alu;
  word_t       shift;
  logic [32:0] sum;
  logic [63:0] prod;
  logic        carry_in;
  logic        add_ovf;
  logic        sub_ovf;
  logic        alu_op;
  logic        carry_q;
  logic        overflow_q;

  function automatic word_t pick(fwd_sel_e sel, word_t own);
    case (sel)
      fwd_wb:    return wb_data;
      fwd_alu:   return mem.alu;
      fwd_shift: return mem.shift;
      fwd_pc4:   return mem.pc + 32'd4;
      fwd_imm:   return mem.imm;
      default:   return own;
    endcase
  endfunction

  always_comb begin
    op_a = pick(fwd_a, ex.a);
    op_b = pick(fwd_b, ex.b);
    op_w = pick(fwd_w, ex.w);
  end

  // A jump adds its A operand to its own PC.
  assign in1 = (ex.dec.opc == op_jump) ? ex.pc : op_a;
  assign in2 = (ex.dec.opc == op_jump) ? op_a : op_b;

  assign carry_in = (ex.dec.func == 4'd1) && carry_q;
  assign sum      = {1'b0, in1} + {1'b0, in2} + {32'd0, carry_in};
  assign diff     = in1 - in2;
  assign prod     = {32'd0, in1} * {32'd0, in2};
  assign add_ovf  = (in1[31] == in2[31]) && (sum[31] != in1[31]);
  assign sub_ovf  = (in1[31] != in2[31]) && (diff[31] != in1[31]);
  assign alu_op   = ex.dec.opc inside {op_normal, op_out, op_jump,
                                       op_jump_zero, op_jump_nonzero};

  always_comb begin
    case (ex.dec.func)
      4'd0, 4'd1: alu = sum[31:0];
      4'd2:       alu = diff;
      4'd3:       alu = {31'd0, carry_q};
      4'd4:       alu = {31'd0, overflow_q};
      4'd5:       alu = in1 + 32'd1;
      4'd6:       alu = in1 - 32'd1;
      4'd7:       alu = prod[31:0];
      4'd8:       alu = prod[63:32];
      4'd9:       alu = in1 & in2;
      4'd10:      alu = in1 | in2;
      4'd11:      alu = in1 ^ in2;
      4'd12:      alu = {31'd0, in1 == in2};
      4'd13:      alu = {31'd0, $signed(in1) < $signed(in2)};
      4'd14:      alu = {31'd0, in1 < in2};
      default:    alu = in2;
    endcase
  end

  always_comb begin
    case (ex.dec.func[1:0])
      2'd0:    shift = op_a << op_b;
      2'd1:    shift = op_a >> op_b;
      2'd2:    shift = word_t'($signed(op_a) >>> op_b);
      // Rotate right by the low five bits.
      default: shift = (op_a >> op_b[4:0]) | (op_a << (6'd32 - {1'b0, op_b[4:0]}));
    endcase
  end

  always_comb begin
    case (ex.dec.opc)
      op_jump: begin
        jump_taken = 1'b1;
        jump_addr  = alu;
      end
      op_jump_zero: begin
        jump_taken = alu == '0;
        jump_addr  = ex.pc + op_w;
      end
      op_jump_nonzero: begin
        jump_taken = alu != '0;
        jump_addr  = ex.pc + op_w;
      end
      default: begin
        jump_taken = 1'b0;
        jump_addr  = alu;
      end
    endcase
  end

  always_comb begin
    res.pc     = ex.pc;
    res.a      = op_a;
    res.b      = op_b;
    res.w      = op_w;
    res.imm    = ex.dec.imm;
    res.alu    = alu;
    res.shift  = shift;
    res.addr_w = ex.dec.addr_w;
    res.opc    = ex.dec.opc;
    res.wr     = ex.dec.opc inside {op_normal, op_shift, op_load, op_out, op_jump,
                                    op_load_const, op_load_upper};
  end

  // Flags change only when the instruction leaves execute.
  always_ff @(posedge clk) begin
    if (reset) begin
      carry_q    <= 1'b0;
      overflow_q <= 1'b0;
    end else if (ex_en && alu_op) begin
      if (ex.dec.func == 4'd0 || ex.dec.func == 4'd1) begin
        carry_q <= sum[32];
      end
      if (ex.dec.func == 4'd0) begin
        overflow_q <= add_ovf;
      end else if (ex.dec.func == 4'd2) begin
        overflow_q <= sub_ovf;
      end
    end
  end

endmodule

//--- rtl/forward_unit.sv
`timescale 1ns/1ps

module forward_unit
  import agp32_pkg::*;
(
  input  reg_addr_t ex_addr_a,
  input  reg_addr_t ex_addr_b,
  input  reg_addr_t ex_addr_w,
  input  logic      ex_imm_a,
  input  logic      ex_imm_b,
  input  logic      ex_imm_w,
  input  opcode_e   ex_opc,
  input  reg_addr_t mem_addr_w,
  input  reg_addr_t wb_addr_w,
  input  opcode_e   mem_opc,
  input  logic      mem_wr,
  input  logic      wb_wr,
  output fwd_sel_e  fwd_a,
  output fwd_sel_e  fwd_b,
  output fwd_sel_e  fwd_w
);

  fwd_sel_e mem_src;
  logic     reads_a;
  logic     reads_b;
  logic     reads_w;

  // Value the memory stage can offer; a load has none until writeback.
  always_comb begin
    case (mem_opc)
      op_normal, op_out:            mem_src = fwd_alu;
      op_shift:                     mem_src = fwd_shift;
      op_jump:                      mem_src = fwd_pc4;
      op_load_const, op_load_upper: mem_src = fwd_imm;
      default:                      mem_src = fwd_reg;
    endcase
  end

  assign reads_a = ex_opc inside {op_normal, op_shift, op_store, op_load, op_out,
                                  op_jump, op_jump_zero, op_jump_nonzero};
  assign reads_b = ex_opc inside {op_normal, op_shift, op_store, op_out,
                                  op_jump_zero, op_jump_nonzero};
  assign reads_w = ex_opc inside {op_jump_zero, op_jump_nonzero, op_load_upper};

  function automatic fwd_sel_e select(reg_addr_t addr, logic imm, logic reads);
    if (!reads || imm) begin
      return fwd_reg;
    end
    if (mem_wr && (addr == mem_addr_w) && (mem_src != fwd_reg)) begin
      return mem_src;
    end
    if (wb_wr && (addr == wb_addr_w)) begin
      return fwd_wb;
    end
    return fwd_reg;
  endfunction

  always_comb begin
    fwd_a = select(ex_addr_a, ex_imm_a, reads_a);
    fwd_b = select(ex_addr_b, ex_imm_b, reads_b);
    fwd_w = select(ex_addr_w, ex_imm_w, reads_w);
  end

endmodule

//--- rtl/instr_decode.sv
`timescale 1ns/1ps

module instr_decode
  import agp32_pkg::*;
(
  input  word_t    instr,
  output decoded_t dec
);

  opcode_e opc;
  logic    upper_form;

  assign upper_form = instr[23:9] == '0;

  // Opcode selection.
  always_comb begin
    if (instr[24]) begin
      if (instr[31]) begin
        opc = op_load_const;
      end else if (upper_form) begin
        opc = op_load_upper;
      end else begin
        opc = op_nop;
      end
    end else begin
      case (instr[5:0])
        6'd0:    opc = op_normal;
        6'd1:    opc = op_shift;
        6'd2:    opc = op_store;
        6'd4:    opc = op_load;
        6'd6:    opc = op_out;
        6'd9:    opc = op_jump;
        6'd10:   opc = op_jump_zero;
        6'd11:   opc = op_jump_nonzero;
        default: opc = op_nop;
      endcase
      // W is an immediate only for the conditional jumps.
      if (instr[31] && !(opc inside {op_jump_zero, op_jump_nonzero})) begin
        opc = op_nop;
      end
    end
  end

  always_comb begin
    dec.addr_a = instr[22:17];
    dec.addr_b = instr[15:10];
    dec.addr_w = instr[30:25];
    dec.imm_a  = instr[23];
    dec.imm_b  = instr[16];
    dec.imm_w  = instr[31];
    dec.opc    = opc;

    case (opc)
      op_normal, op_out, op_jump, op_jump_zero, op_jump_nonzero: begin
        dec.func = instr[9:6];
      end
      op_shift: dec.func = {2'b00, instr[7:6]};
      // Plain AND for instructions that do not use the ALU result.
      default:  dec.func = 4'd9;
    endcase

    if (instr[24] && instr[31]) begin
      if (instr[23]) begin
        dec.imm = '0 - word_t'(instr[22:0]);
      end else begin
        dec.imm = word_t'(instr[22:0]);
      end
    end else if (instr[24] && upper_form) begin
      dec.imm = word_t'(instr[8:0]);
    end else begin
      dec.imm = '0;
    end
  end

endmodule

//--- rtl/mem_controller.sv
`timescale 1ns/1ps

module mem_controller
  import agp32_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       ready,
  input  logic       jump_taken,
  input  opcode_e    mem_opc,
  input  word_t      mem_a,
  input  word_t      mem_b,
  output logic       pc_en,
  output logic       id_en,
  output logic       ex_en,
  output logic       mem_en,
  output logic       wb_en,
  output logic       flush_id,
  output logic       nop_ex,
  output mem_cmd_e   command,
  output word_t      data_addr,
  output word_t      data_wdata,
  output logic [3:0] data_wstrb
);

  ctrl_state_e state;
  logic        is_load;
  logic        is_store;
  logic        issue;

  assign is_load  = mem_opc == op_load;
  assign is_store = mem_opc == op_store;
  assign issue    = (state == st_run) && ready && (is_load || is_store);

  always_comb begin
    pc_en    = 1'b0;
    id_en    = 1'b0;
    ex_en    = 1'b0;
    mem_en   = 1'b0;
    wb_en    = 1'b0;
    flush_id = 1'b0;
    nop_ex   = 1'b0;
    case (state)
      st_run: begin
        if (ready && !is_load && !is_store) begin
          pc_en    = 1'b1;
          ex_en    = 1'b1;
          mem_en   = 1'b1;
          wb_en    = 1'b1;
          id_en    = !jump_taken;
          // Kill the two instructions fetched behind a taken jump.
          flush_id = jump_taken;
          nop_ex   = jump_taken;
        end
      end
      st_resume: begin
        mem_en = 1'b1;
        wb_en  = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_run;
      command <= cmd_none;
    end else begin
      case (state)
        st_run: begin
          if (issue) begin
            state   <= st_wait_mem;
            command <= is_load ? cmd_read : cmd_write;
          end
        end
        st_wait_mem: begin
          command <= cmd_none;
          if (ready && (command == cmd_none)) begin
            state <= st_resume;
          end
        end
        default: state <= st_run;
      endcase
    end
  end

  // Load address in A, store address in B with data in A.
  always_ff @(posedge clk) begin
    if (issue) begin
      data_addr  <= is_load ? mem_a : mem_b;
      data_wdata <= mem_a;
      data_wstrb <= is_store ? 4'hf : 4'h0;
    end
  end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file
  import agp32_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t addr_a,
  input  reg_addr_t addr_b,
  input  reg_addr_t addr_w,
  input  reg_addr_t wr_addr,
  input  logic      wr_en,
  input  word_t     wr_data,
  output word_t     rd_a,
  output word_t     rd_b,
  output word_t     rd_w
);

  word_t regs [64];

  // A read of the register written this cycle sees the new value.
  function automatic word_t read_port(reg_addr_t addr);
    if (wr_en && (wr_addr == addr)) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rd_a = read_port(addr_a);
    rd_b = read_port(addr_b);
    rd_w = read_port(addr_w);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f all.f --top-module tb_agp32 -o tb_agp32
output=$(./obj_dir/tb_agp32)
echo "$output"
if echo "$output" | grep -q "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi

//--- test/tb_isa_model.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

word_t m_regs [64];
word_t m_mem [64];
logic  m_carry;
logic  m_ovf;

function automatic word_t sext6(reg_addr_t x);
  return {{26{x[5]}}, x};
endfunction

// Flags are read before they are updated, as in a sequential machine.
function automatic word_t model_alu(func_t f, word_t x, word_t y);
  logic [32:0] s;
  logic [63:0] p;
  word_t       d;
  word_t       r;
  s = {1'b0, x} + {1'b0, y} + {32'd0, (f == 4'd1) && m_carry};
  d = x - y;
  p = {32'd0, x} * {32'd0, y};
  case (f)
    4'd0, 4'd1: r = s[31:0];
    4'd2:       r = d;
    4'd3:       r = {31'd0, m_carry};
    4'd4:       r = {31'd0, m_ovf};
    4'd5:       r = x + 32'd1;
    4'd6:       r = x - 32'd1;
    4'd7:       r = p[31:0];
    4'd8:       r = p[63:32];
    4'd9:       r = x & y;
    4'd10:      r = x | y;
    4'd11:      r = x ^ y;
    4'd12:      r = {31'd0, x == y};
    4'd13:      r = {31'd0, $signed(x) < $signed(y)};
    4'd14:      r = {31'd0, x < y};
    default:    r = y;
  endcase
  if (f == 4'd0 || f == 4'd1) begin
    m_carry = s[32];
  end
  if (f == 4'd0) begin
    m_ovf = (x[31] == y[31]) && (s[31] != x[31]);
  end else if (f == 4'd2) begin
    m_ovf = (x[31] != y[31]) && (d[31] != x[31]);
  end
  return r;
endfunction

function automatic word_t model_shift(logic [1:0] s, word_t x, word_t y);
  logic [63:0] twice;
  twice = {x, x} >> y[4:0];
  case (s)
    2'd0:    return x << y;
    2'd1:    return x >> y;
    2'd2:    return word_t'($signed(x) >>> y);
    default: return twice[31:0];
  endcase
endfunction

// Runs the program one instruction at a time until a jump to itself.
function automatic void run_model();
  word_t      pc;
  word_t      ins;
  word_t      a;
  word_t      b;
  word_t      wv;
  word_t      r;
  word_t      next;
  reg_addr_t  w;
  logic [9:0] last;
  pc = reset_pc;
  last = '0;
  m_regs = '{default: '0};
  m_carry = 1'b0;
  m_ovf = 1'b0;
  for (int i = 0; i < 64; i++) begin
    m_mem[i] = fill_word(i);
  end
  for (int steps = 0; steps < 1000; steps++) begin
    ins = prog[pc[7:2]];
    w = ins[30:25];
    a = ins[23] ? sext6(ins[22:17]) : m_regs[ins[22:17]];
    b = ins[16] ? sext6(ins[15:10]) : m_regs[ins[15:10]];
    wv = ins[31] ? sext6(w) : m_regs[w];
    next = pc + 32'd4;
    if (ins[24]) begin
      if (ins[31]) begin
        m_regs[w] = ins[23] ? -word_t'(ins[22:0]) : word_t'(ins[22:0]);
      end else if (ins[23:9] == 15'd0) begin
        m_regs[w] = {ins[8:0], m_regs[w][22:0]};
      end
    end else if (!ins[31] || ins[5:0] == 6'd10 || ins[5:0] == 6'd11) begin
      case (ins[5:0])
        6'd0: m_regs[w] = model_alu(ins[9:6], a, b);
        6'd1: m_regs[w] = model_shift(ins[7:6], a, b);
        6'd2: begin
          m_mem[b[7:2]] = a;
          exp_st_addr.push_back(b);
          exp_st_data.push_back(a);
        end
        6'd4: m_regs[w] = m_mem[a[7:2]];
        6'd6: begin
          r = model_alu(ins[9:6], a, b);
          m_regs[w] = r;
          if (r[9:0] != last) begin
            exp_outs.push_back(r[9:0]);
            last = r[9:0];
          end
        end
        6'd9: begin
          r = model_alu(ins[9:6], pc, a);
          m_regs[w] = pc + 32'd4;
          if (r == pc) begin
            return;
          end
          next = r;
        end
        6'd10: begin
          if (model_alu(ins[9:6], a, b) == '0) begin
            next = pc + wv;
          end
        end
        6'd11: begin
          if (model_alu(ins[9:6], a, b) != '0) begin
            next = pc + wv;
          end
        end
        default: ;
      endcase
    end
    pc = next;
  end
endfunction

`endif

//--- test/tb_agp32.sv
`timescale 1ns/1ps

module tb_agp32
  import agp32_pkg::*;
;

  localparam word_t reset_pc = 32'd0;

  logic                 clk;
  logic                 reset;
  logic                 ready;
  word_t                inst_rdata;
  word_t                data_rdata;
  word_t                pc;
  word_t                data_addr;
  word_t                data_wdata;
  mem_cmd_e             command;
  logic [3:0]           data_wstrb;
  logic [out_width-1:0] data_out;

  word_t                prog [64];
  word_t                dmem [64];
  logic [out_width-1:0] exp_outs [$];
  word_t                exp_st_addr [$];
  word_t                exp_st_data [$];
  logic [out_width-1:0] last_out;
  mem_cmd_e             pending_cmd;
  word_t                rng;
  int                   errors;
  int                   out_idx;
  int                   st_idx;
  int                   cycles;
  int                   delay;

  function automatic word_t fill_word(int i);
    return (word_t'(i) * 32'h01010101) ^ 32'ha5c30000;
  endfunction

  `include "tb_isa_model.svh"

  agp32_core #(.reset_pc(reset_pc)) uut (
    .clk        (clk),
    .reset      (reset),
    .ready      (ready),
    .inst_rdata (inst_rdata),
    .data_rdata (data_rdata),
    .pc         (pc),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .command    (command),
    .data_wstrb (data_wstrb),
    .data_out   (data_out)
  );

  always #10 clk = ~clk;

  assign inst_rdata = (pc < 32'd256) ? prog[pc[7:2]] : 32'd63;

  function automatic word_t xorshift(word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic word_t enc(opcode_e op, func_t f, reg_addr_t w, logic iw,
                                reg_addr_t a, logic ia, reg_addr_t b, logic ib);
    return {iw, w, 1'b0, ia, a, ib, b, f, 1'b0, op};
  endfunction

  function automatic word_t load_const(reg_addr_t w, logic neg, logic [22:0] v);
    return {1'b1, w, 1'b1, neg, v};
  endfunction

  function automatic word_t load_upper(reg_addr_t w, logic [8:0] v);
    return {1'b0, w, 1'b1, 15'd0, v};
  endfunction

  task automatic check_word(string name, word_t exp, word_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_out(string name, logic [out_width-1:0] exp, logic [out_width-1:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_cmd(string name, mem_cmd_e exp, mem_cmd_e act);
    if (exp !== act) begin
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_strb(string name, logic [3:0] exp, logic [3:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic load_program();
    prog = '{default: 32'd63};
    prog[0]  = load_const(6'd1, 1'b0, 23'd5);
    prog[1]  = load_const(6'd2, 1'b0, 23'd3);
    prog[2]  = enc(op_normal, 4'd0, 6'd3, 0, 6'd1, 0, 6'd2, 0);
    prog[3]  = enc(op_normal, 4'd2, 6'd4, 0, 6'd3, 0, 6'd2, 0);
    prog[4]  = enc(op_normal, 4'd7, 6'd5, 0, 6'd4, 0, 6'd3, 0);
    prog[5]  = enc(op_out, 4'd0, 6'd6, 0, 6'd5, 0, 6'd1, 0);
    prog[6]  = enc(op_out, 4'd13, 6'd7, 0, 6'd2, 0, 6'd5, 0);
    prog[7]  = enc(op_shift, 4'd0, 6'd8, 0, 6'd1, 0, 6'd2, 1);
    prog[8]  = enc(op_out, 4'd0, 6'd9, 0, 6'd8, 0, 6'd0, 1);
    prog[9]  = load_const(6'd10, 1'b1, 23'd100);
    prog[10] = enc(op_shift, 4'd2, 6'd11, 0, 6'd10, 0, 6'd1, 1);
    prog[11] = enc(op_out, 4'd0, 6'd12, 0, 6'd11, 0, 6'd0, 1);
    prog[12] = enc(op_shift, 4'd3, 6'd13, 0, 6'd1, 0, 6'd1, 1);
    prog[13] = enc(op_shift, 4'd1, 6'd14, 0, 6'd13, 0, 6'd1, 1);
    prog[14] = enc(op_out, 4'd0, 6'd15, 0, 6'd14, 0, 6'd1, 0);
    prog[15] = load_upper(6'd1, 9'h1ab);
    prog[16] = enc(op_shift, 4'd1, 6'd18, 0, 6'd1, 0, 6'd20, 1);
    prog[17] = enc(op_out, 4'd0, 6'd17, 0, 6'd18, 0, 6'd0, 1);
    prog[18] = load_const(6'd20, 1'b0, 23'd16);
    prog[19] = enc(op_store, 4'd0, 6'd0, 0, 6'd5, 0, 6'd20, 0);
    prog[20] = enc(op_store, 4'd0, 6'd0, 0, 6'd11, 0, 6'd20, 1);
    prog[21] = enc(op_load, 4'd0, 6'd21, 0, 6'd20, 0, 6'd0, 0);
    prog[22] = enc(op_out, 4'd0, 6'd22, 0, 6'd21, 0, 6'd1, 1);
    prog[23] = enc(op_load, 4'd0, 6'd23, 0, 6'd20, 1, 6'd0, 0);
    prog[24] = enc(op_out, 4'd0, 6'd24, 0, 6'd23, 0, 6'd21, 0);
    prog[25] = enc(op_jump, 4'd0, 6'd25, 0, 6'd8, 1, 6'd0, 0);
    prog[26] = enc(op_out, 4'd0, 6'd26, 0, 6'd1, 0, 6'd0, 1);
    prog[27] = enc(op_out, 4'd0, 6'd27, 0, 6'd25, 0, 6'd0, 1);
    prog[28] = enc(op_jump_zero, 4'd0, 6'd8, 1, 6'd1, 0, 6'd0, 1);
    prog[29] = enc(op_out, 4'd0, 6'd28, 0, 6'd2, 0, 6'd7, 1);
    prog[30] = enc(op_jump_nonzero, 4'd0, 6'd8, 1, 6'd2, 0, 6'd0, 1);
    prog[31] = enc(op_out, 4'd0, 6'd29, 0, 6'd2, 0, 6'd2, 0);
    prog[32] = enc(op_out, 4'd0, 6'd30, 0, 6'd2, 0, 6'd20, 1);
    prog[33] = enc(op_jump, 4'd0, 6'd63, 0, 6'd0, 1, 6'd0, 0);
  endtask

  // Data memory with a random busy time per command.
  always begin
    @(negedge clk);
    if (!reset && command != cmd_none) begin
      pending_cmd = command;
      ready = 1'b0;
      rng = xorshift(rng);
      delay = int'(rng % 32'd4) + 1;
      repeat (delay) @(negedge clk);
      if (pending_cmd == cmd_write) begin
        dmem[data_addr[7:2]] = data_wdata;
      end else begin
        data_rdata = dmem[data_addr[7:2]];
      end
      ready = 1'b1;
    end
  end

  // Compares stores and output changes in program order.
  always @(negedge clk) begin
    if (!reset) begin
      if (command == cmd_write) begin
        if (st_idx >= exp_st_addr.size()) begin
          $display("Store issued that the program does not contain");
          errors++;
        end else begin
          check_word("store address", exp_st_addr[st_idx], data_addr);
          check_word("store data", exp_st_data[st_idx], data_wdata);
          check_strb("store strobe", 4'hf, data_wstrb);
        end
        st_idx++;
      end
      if (data_out != last_out) begin
        if (out_idx >= exp_outs.size()) begin
          $display("data_out changed after the last expected value");
          errors++;
        end else begin
          check_out("data_out", exp_outs[out_idx], data_out);
        end
        last_out = data_out;
        out_idx++;
      end
    end
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    ready = 1'b1;
    data_rdata = '0;
    rng = 32'd70;
    errors = 0;
    out_idx = 0;
    st_idx = 0;
    last_out = '0;
    load_program();
    for (int i = 0; i < 64; i++) begin
      dmem[i] = fill_word(i);
    end
    run_model();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_cmd("reset command", cmd_none, command);
    check_out("reset data_out", '0, data_out);
    check_word("reset pc", reset_pc, pc);
    cycles = 0;
    while ((out_idx < exp_outs.size() || st_idx < exp_st_addr.size()) && cycles < 5000) begin
      @(negedge clk);
      cycles++;
    end
    if (out_idx < exp_outs.size() || st_idx < exp_st_addr.size()) begin
      $display("Timeout: the final output value never appeared");
      errors++;
    end
    repeat (20) @(negedge clk);
    $display("Errors: %0d, outputs seen %0d of %0d, stores seen %0d of %0d",
             errors, out_idx, exp_outs.size(), st_idx, exp_st_addr.size());
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
